// ==== list.f ====
+incdir+include
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/cpu_top.sv
verif/cpu_bus_checker.sv
verif/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - hw/cpu_pkg.sv
      - hw/cpu_alu.sv
      - hw/cpu_regfile.sv
      - hw/cpu_control.sv
      - hw/cpu_datapath.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/cpu_bus_checker.sv
      - verif/cpu_tb.sv

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb;

  localparam int MEM_WORDS = 2048;
  localparam logic [31:0] DBASE = 32'h0000_1000; // data region

  logic                 clk_i;
  logic                 rst_i;
  logic                 ack_i;
  logic [`CPU_XLEN-1:0] dat_i;
  logic [`CPU_XLEN-1:0] adr_o, dat_o;
  logic [3:0]           sel_o;
  logic                 cyc_o, we_o, halt_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] prog [$];
  cpu_pkg::bus_req_t exp_stores [$];
  int          waits [$]; // wait states per access, drawn up front

  logic armed;
  int   wait_left;
  int   cycle_count;
  int   cycle_limit;
  int   n_instr;

  cpu_top uut (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ack_i  (ack_i),
    .dat_i  (dat_i),
    .adr_o  (adr_o),
    .dat_o  (dat_o),
    .sel_o  (sel_o),
    .cyc_o  (cyc_o),
    .we_o   (we_o),
    .halt_o (halt_o)
  );

  bind cpu_top cpu_bus_checker u_bus_checker (.*);

  always #4 clk_i = ~clk_i;

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_store(input cpu_pkg::bus_req_t got, input cpu_pkg::bus_req_t exp);
    if (got.adr !== exp.adr || got.sel !== exp.sel || got.dat !== exp.dat) begin
      $display("Error at %0t ns: store adr %h sel %b dat %h, expected adr %h sel %b dat %h",
               $time, got.adr, got.sel, got.dat, exp.adr, exp.sel, exp.dat);
      stop_run();
    end
  endtask

  task automatic check_word(input int idx, input logic [`CPU_XLEN-1:0] got,
                            input logic [`CPU_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: memory word %0d is %h, expected %h", $time, idx, got, exp);
      stop_run();
    end
  endtask

  function automatic int word_index(input logic [31:0] adr);
    return int'(adr[12:2]);
  endfunction

  function automatic logic [31:0] encode(input cpu_pkg::opcode_e op, input int rd,
                                         input int rs1, input int rs2, input int imm);
    logic [31:0] w;
    w = {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    return w;
  endfunction

  function automatic void emit(input cpu_pkg::opcode_e op, input int rd, input int rs1,
                               input int rs2, input int imm);
    prog.push_back(encode(op, rd, rs1, rs2, imm));
  endfunction

  // instruction-level ISA model over ref_mem
  function automatic int cpu_ref_run();
    logic [31:0]       r [16];
    logic [31:0]       pc, nxt, ins, a, b, sv, ea, res;
    logic              z;
    logic [1:0]        ln;
    int                n, rd;
    bit                run, wr;
    cpu_pkg::opcode_e  op;
    cpu_pkg::bus_req_t st;
    pc = `CPU_RESET_PC;
    z = 1'b0;
    n = 0;
    run = 1'b1;
    for (int i = 0; i < 16; i++) r[i] = '0;
    while (run && n < 100000) begin
      ins = ref_mem[word_index(pc)];
      op  = cpu_pkg::opcode_e'(ins[31:28]);
      rd  = ins[27:24];
      a   = r[ins[23:20]];
      b   = r[ins[19:16]];
      sv  = {{16{ins[15]}}, ins[15:0]};
      ea  = a + sv;
      ln  = ea[1:0];
      nxt = pc + 4;
      res = '0;
      wr  = 1'b1; // alu result goes to rd and the zero flag
      case (op)
        cpu_pkg::OP_ADD:  res = a + b;
        cpu_pkg::OP_SUB:  res = a - b;
        cpu_pkg::OP_AND:  res = a & b;
        cpu_pkg::OP_OR:   res = a | b;
        cpu_pkg::OP_XOR:  res = a ^ b;
        cpu_pkg::OP_ADDI: res = a + sv;
        default:          wr = 1'b0;
      endcase
      if (wr) begin
        r[rd] = res;
        z = (res == 0);
      end
      case (op)
        cpu_pkg::OP_LDI:  r[rd] = {16'h0000, ins[15:0]};
        cpu_pkg::OP_LD:   r[rd] = ref_mem[word_index(ea)];
        cpu_pkg::OP_LDB:  r[rd] = {24'h0, ref_mem[word_index(ea)][8*ln +: 8]};
        cpu_pkg::OP_ST: begin
          st = '{adr: ea, dat: b, sel: 4'b1111, we: 1'b1};
          exp_stores.push_back(st);
          ref_mem[word_index(ea)] = b;
        end
        cpu_pkg::OP_STB: begin
          st = '{adr: ea, dat: {4{b[7:0]}}, sel: 4'b0001 << ln, we: 1'b1};
          exp_stores.push_back(st);
          ref_mem[word_index(ea)][8*ln +: 8] = b[7:0];
        end
        cpu_pkg::OP_BEQ: if (z) nxt = nxt + (sv << 2);
        cpu_pkg::OP_BNE: if (!z) nxt = nxt + (sv << 2);
        default:         run = wr; // alu ops go on, anything else halts
      endcase
      r[0] = '0;
      pc = nxt;
      n++;
    end
    return n;
  endfunction

  task automatic build_program();
    int loop_at;
    emit(cpu_pkg::OP_LDI, 1, 0, 0, DBASE);
    // random operand pairs through every alu op
    for (int p = 0; p < 4; p++) begin
      emit(cpu_pkg::OP_LD, 2, 1, 0, 8 * p);
      emit(cpu_pkg::OP_LD, 3, 1, 0, 8 * p + 4);
      for (int k = 0; k < 5; k++) begin
        emit(cpu_pkg::opcode_e'(k), 4, 2, 3, 0);
        emit(cpu_pkg::OP_ST, 0, 1, 4, 'h100 + 4 * (5 * p + k));
      end
    end
    for (int k = 0; k < 4; k++) begin
      emit(cpu_pkg::OP_ADDI, 5, 2, 0, -(1 + int'($urandom % 32767)));
      emit(cpu_pkg::OP_ST, 0, 1, 5, 'h180 + 4 * k);
      emit(cpu_pkg::OP_LDI, 6, 0, 0, 'h8000 | ($urandom % 'h8000));
      emit(cpu_pkg::OP_ST, 0, 1, 6, 'h190 + 4 * k);
    end
    for (int ln = 0; ln < 4; ln++) begin
      emit(cpu_pkg::OP_LDI, 7, 0, 0, 'h80 | ($urandom % 'h10000)); // byte top bit set
      emit(cpu_pkg::OP_STB, 0, 1, 7, 'h200 + ln);
    end
    for (int ln = 0; ln < 4; ln++) begin
      emit(cpu_pkg::OP_LDB, 8, 1, 0, 'h200 + ln);
      emit(cpu_pkg::OP_ST, 0, 1, 8, 'h210 + 4 * ln);
    end
    // taken branches skip the store that follows
    emit(cpu_pkg::OP_SUB, 9, 2, 2, 0);
    emit(cpu_pkg::OP_BEQ, 0, 0, 0, 1);
    emit(cpu_pkg::OP_ST, 0, 1, 2, 'h280);
    emit(cpu_pkg::OP_BNE, 0, 0, 0, 1);
    emit(cpu_pkg::OP_ST, 0, 1, 3, 'h284);
    emit(cpu_pkg::OP_ADDI, 9, 0, 0, 1);
    emit(cpu_pkg::OP_BEQ, 0, 0, 0, 1);
    emit(cpu_pkg::OP_ST, 0, 1, 3, 'h288);
    emit(cpu_pkg::OP_BNE, 0, 0, 0, 1);
    emit(cpu_pkg::OP_ST, 0, 1, 2, 'h28c);
    emit(cpu_pkg::OP_ST, 0, 1, 9, 'h290);
    // countdown loop closed by a backward branch
    emit(cpu_pkg::OP_LDI, 11, 0, 0, DBASE + 'h300);
    emit(cpu_pkg::OP_LDI, 10, 0, 0, 6);
    loop_at = prog.size();
    emit(cpu_pkg::OP_ST, 0, 11, 10, 0);
    emit(cpu_pkg::OP_ADDI, 11, 11, 0, 4);
    emit(cpu_pkg::OP_ADDI, 10, 10, 0, -1);
    emit(cpu_pkg::OP_BNE, 0, 0, 0, loop_at - (prog.size() + 1));
    emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
  endtask

  // memory slave with 0 to 3 extra wait states per access
  always @(posedge clk_i) begin : memory_model
    int w;
    if (rst_i) begin
      ack_i <= 1'b0;
      armed <= 1'b0;
    end else if (ack_i) begin
      ack_i <= 1'b0;
      armed <= 1'b0;
      if (we_o) begin
        for (int k = 0; k < 4; k++) begin
          if (sel_o[k]) mem[word_index(adr_o)][8*k +: 8] <= dat_o[8*k +: 8];
        end
      end
    end else if (cyc_o) begin
      w = armed ? wait_left : waits.pop_front();
      armed <= 1'b1;
      if (w == 0) begin
        ack_i <= 1'b1;
        dat_i <= mem[word_index(adr_o)];
      end else begin
        wait_left <= w - 1;
      end
    end
  end

  always @(posedge clk_i) begin : compare_stores
    cpu_pkg::bus_req_t got, exp;
    if (!rst_i && cyc_o && we_o && ack_i) begin
      got = '{adr: adr_o, dat: dat_o, sel: sel_o, we: we_o};
      if (exp_stores.size() == 0) begin
        $display("A store to %h arrived after all expected stores", adr_o);
        stop_run();
      end else begin
        exp = exp_stores.pop_front();
        check_store(got, exp);
      end
    end
  end

  always @(posedge clk_i) begin : assertion_watch
    if (uut.u_bus_checker.fail_count != 0) begin
      $display("A bus protocol assertion failed");
      stop_run();
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: no halt after %0d cycles", cycle_count);
      stop_run();
    end
  end

  initial begin
    clk_i = 1'b0;
    rst_i = 1'b1;
    ack_i = 1'b0;
    dat_i = '0;
    armed = 1'b0;
    wait_left = 0;
    cycle_count = 0;
    cycle_limit = 1000000;
    void'($urandom(32'h99a6_f522));
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 4) * 32'h0100_0193 ^ 32'hc3a5_0f1e;
    end
    for (int i = 0; i < 8; i++) mem[word_index(DBASE) + i] = $urandom;
    build_program();
    foreach (prog[i]) mem[i] = prog[i];
    foreach (mem[i]) ref_mem[i] = mem[i];
    n_instr = cpu_ref_run();
    cycle_limit = n_instr * 12 + 200;
    repeat (2 * n_instr) waits.push_back(int'($urandom % 4)); // at most two accesses each
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    while (!halt_o) @(posedge clk_i);
    repeat (20) begin
      @(posedge clk_i);
      if (cyc_o || !halt_o) begin
        $display("Bus cycle or halt drop seen after HALT");
        stop_run();
      end
    end
    if (exp_stores.size() != 0) begin
      $display("Halted with %0d expected stores missing", exp_stores.size());
      stop_run();
    end
    for (int i = 0; i < MEM_WORDS; i++) check_word(i, mem[i], ref_mem[i]);
    if (uut.u_bus_checker.fail_count != 0) begin
      $display("A bus protocol assertion failed");
      stop_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verif/cpu_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_bus_checker (
  input wire                 clk_i,
  input wire                 rst_i,
  input wire                 ack_i,
  input wire [`CPU_XLEN-1:0] adr_o,
  input wire [`CPU_XLEN-1:0] dat_o,
  input wire [3:0]           sel_o,
  input wire                 cyc_o,
  input wire                 we_o,
  input wire                 halt_o
);

  int unsigned fail_count = 0; // failed assertions so far

  // request held until the slave answers
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (cyc_o && !ack_i) |=> (cyc_o && $stable(adr_o) && $stable(we_o)
                           && $stable(sel_o) && $stable(dat_o)))
    else begin
      $error("bus request changed before ack");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk_i) rst_i |-> (!cyc_o && !we_o))
    else begin
      $error("bus strobes active during reset");
      fail_count++;
    end

  a_halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |=> halt_o)
    else begin
      $error("halt dropped without reset");
      fail_count++;
    end

  a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |-> !cyc_o)
    else begin
      $error("bus cycle while halted");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  ack_i,
  input  wire [`CPU_XLEN-1:0]  dat_i,
  output logic [`CPU_XLEN-1:0] adr_o,
  output logic [`CPU_XLEN-1:0] dat_o,
  output logic [3:0]           sel_o,
  output logic                 cyc_o,
  output logic                 we_o,
  output logic                 halt_o
);

  cpu_pkg::ctrl_t      ctrl;
  cpu_pkg::opcode_e    opcode;
  cpu_pkg::alu_flags_t alu_flags;
  cpu_pkg::bus_req_t   dp_bus, bus_req;
  logic                zero, ctl_we;
  logic [3:0]          raddr1, raddr2, waddr;
  logic [`CPU_XLEN-1:0] wdata, rdata1, rdata2, alu_in1, alu_in2, alu_out;

  cpu_control u_control (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .opcode_i (opcode),
    .zero_i   (zero),
    .ack_i    (ack_i),
    .ctrl_o   (ctrl),
    .cyc_o    (cyc_o),
    .we_o     (ctl_we),
    .halt_o   (halt_o)
  );

  cpu_datapath u_datapath (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ctrl_i      (ctrl),
    .dat_i       (dat_i),
    .ack_i       (ack_i),
    .opcode_o    (opcode),
    .zero_o      (zero),
    .bus_o       (dp_bus),
    .raddr1_o    (raddr1),
    .raddr2_o    (raddr2),
    .waddr_o     (waddr),
    .wdata_o     (wdata),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .alu_in1_o   (alu_in1),
    .alu_in2_o   (alu_in2),
    .alu_out_i   (alu_out),
    .alu_flags_i (alu_flags)
  );

  cpu_alu u_alu (
    .in1_i   (alu_in1),
    .in2_i   (alu_in2),
    .op_i    (ctrl.alu_op),
    .out_o   (alu_out),
    .flags_o (alu_flags)
  );

  cpu_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .we_i     (ctrl.reg_write),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  // request = datapath address/data/lanes + control write strobe
  assign bus_req = '{adr: dp_bus.adr, dat: dp_bus.dat, sel: dp_bus.sel, we: ctl_we};

  assign adr_o = bus_req.adr;
  assign dat_o = bus_req.dat;
  assign sel_o = bus_req.sel;
  assign we_o  = bus_req.we;

endmodule

`default_nettype wire

// ==== hw/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_datapath (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire cpu_pkg::ctrl_t   ctrl_i,
  input  wire [`CPU_XLEN-1:0]   dat_i,
  input  wire                   ack_i,
  output cpu_pkg::opcode_e      opcode_o,
  output logic                  zero_o,
  output cpu_pkg::bus_req_t     bus_o,
  output logic [3:0]            raddr1_o,
  output logic [3:0]            raddr2_o,
  output logic [3:0]            waddr_o,
  output logic [`CPU_XLEN-1:0]  wdata_o,
  input  wire [`CPU_XLEN-1:0]   rdata1_i,
  input  wire [`CPU_XLEN-1:0]   rdata2_i,
  output logic [`CPU_XLEN-1:0]  alu_in1_o,
  output logic [`CPU_XLEN-1:0]  alu_in2_o,
  input  wire [`CPU_XLEN-1:0]   alu_out_i,
  input  wire cpu_pkg::alu_flags_t alu_flags_i
);

  logic [`CPU_XLEN-1:0] pc, ir, mar, mdr, a, b;
  cpu_pkg::alu_flags_t  ccr;

  logic [`CPU_XLEN-1:0] sval, uval, pc_rel, adr, ld_data;
  logic [7:0]           ld_byte;
  logic [1:0]           lane;

  // instruction fields
  assign opcode_o = cpu_pkg::opcode_e'(ir[31:28]);
  assign waddr_o  = ir[27:24];
  assign raddr1_o = ir[23:20];
  assign raddr2_o = ir[19:16];
  assign zero_o   = ccr.zero;

  assign sval = {{(`CPU_XLEN-16){ir[15]}}, ir[15:0]};
  assign uval = {{(`CPU_XLEN-16){1'b0}}, ir[15:0]};

  // pc already advanced past the branch, so this is pc + 4 + imm*4
  assign pc_rel = pc + {sval[`CPU_XLEN-3:0], 2'b00};

  // bus side
  assign adr  = ctrl_i.addr_mar ? mar : pc;
  assign lane = adr[1:0];

  always_comb begin
    bus_o.adr = adr;
    bus_o.we  = 1'b0; // write strobe comes from control, merged in top
    if (ctrl_i.byte_op) begin
      bus_o.sel = 4'b0001 << lane;
      bus_o.dat = {(`CPU_XLEN/8){mdr[7:0]}}; // same byte on every lane
    end else begin
      bus_o.sel = 4'b1111;
      bus_o.dat = mdr;
    end
  end

  assign ld_byte = dat_i[8*lane +: 8];
  assign ld_data = ctrl_i.byte_op ? {{(`CPU_XLEN-8){1'b0}}, ld_byte} : dat_i;

  // alu operands
  assign alu_in1_o = a;
  assign alu_in2_o = (ctrl_i.alu2_sel == cpu_pkg::ALU2_SVAL) ? sval : b;

  always_comb begin
    case (ctrl_i.reg_sel)
      cpu_pkg::REG_MDR:  wdata_o = mdr;
      cpu_pkg::REG_UVAL: wdata_o = uval; // no sign ext
      default:           wdata_o = alu_out_i;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      case (ctrl_i.pc_sel)
        cpu_pkg::PC_NEXT: pc <= pc + `CPU_XLEN'd4;
        cpu_pkg::PC_REL:  pc <= pc_rel;
        default:          pc <= pc;
      endcase
      if (ctrl_i.ir_write && ack_i) ir <= dat_i;
      if (ctrl_i.ccr_write) ccr <= alu_flags_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.mar_sel == cpu_pkg::MAR_ALU) mar <= alu_out_i;
    case (ctrl_i.mdr_sel)
      cpu_pkg::MDR_BUS: begin
        if (ack_i) mdr <= ld_data;
      end
      cpu_pkg::MDR_B:   mdr <= b;
      default:          mdr <= mdr;
    endcase
    if (ctrl_i.a_write) a <= rdata1_i;
    if (ctrl_i.b_write) b <= rdata2_i;
  end

endmodule

`default_nettype wire

// ==== hw/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire cpu_pkg::opcode_e opcode_i,
  input  wire                   zero_i,
  input  wire                   ack_i,
  output cpu_pkg::ctrl_t        ctrl_o,
  output logic                  cyc_o,
  output logic                  we_o,
  output logic                  halt_o
);

  cpu_pkg::state_e state, state_d;
  logic            cyc_d, we_d;
  logic            done; // bus transfer completes this edge
  logic            is_load, is_store, is_byte, is_branch, is_reg, is_valid, taken;

  assign done = cyc_o && ack_i;

  always_comb begin
    is_load   = (opcode_i == cpu_pkg::OP_LD) || (opcode_i == cpu_pkg::OP_LDB);
    is_store  = (opcode_i == cpu_pkg::OP_ST) || (opcode_i == cpu_pkg::OP_STB);
    is_byte   = (opcode_i == cpu_pkg::OP_LDB) || (opcode_i == cpu_pkg::OP_STB);
    is_branch = (opcode_i == cpu_pkg::OP_BEQ) || (opcode_i == cpu_pkg::OP_BNE);
    is_reg    = (opcode_i <= cpu_pkg::OP_XOR);
    is_valid  = (opcode_i < cpu_pkg::OP_HALT);
    taken     = (opcode_i == cpu_pkg::OP_BEQ) ? zero_i : !zero_i;
  end

  // next state
  always_comb begin
    state_d = state;
    case (state)
      cpu_pkg::S_FETCH: begin
        if (done) state_d = cpu_pkg::S_DECODE;
      end
      cpu_pkg::S_DECODE: state_d = is_valid ? cpu_pkg::S_EXEC : cpu_pkg::S_HALT;
      cpu_pkg::S_EXEC: begin
        if (is_branch) begin
          state_d = cpu_pkg::S_FETCH;
        end else if (is_load || is_store) begin
          state_d = cpu_pkg::S_MEM;
        end else begin
          state_d = cpu_pkg::S_WB;
        end
      end
      cpu_pkg::S_MEM: begin
        if (done) state_d = is_load ? cpu_pkg::S_WB : cpu_pkg::S_FETCH;
      end
      cpu_pkg::S_WB:   state_d = cpu_pkg::S_FETCH;
      cpu_pkg::S_HALT: state_d = cpu_pkg::S_HALT;
      default:         state_d = cpu_pkg::S_FETCH;
    endcase
  end

  // strobes are registered; a finished transfer always drops cyc for a cycle
  assign cyc_d = ((state_d == cpu_pkg::S_FETCH) || (state_d == cpu_pkg::S_MEM)) && !done;
  assign we_d  = cyc_d && (state_d == cpu_pkg::S_MEM) && is_store;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= cpu_pkg::S_FETCH;
      cyc_o <= 1'b0;
      we_o  <= 1'b0;
    end else begin
      state <= state_d;
      cyc_o <= cyc_d;
      we_o  <= we_d;
    end
  end

  assign halt_o = (state == cpu_pkg::S_HALT);

  // datapath controls
  always_comb begin
    ctrl_o = '0;
    // alu setup held through exec and wb
    case (opcode_i)
      cpu_pkg::OP_SUB: ctrl_o.alu_op = cpu_pkg::ALU_SUB;
      cpu_pkg::OP_AND: ctrl_o.alu_op = cpu_pkg::ALU_AND;
      cpu_pkg::OP_OR:  ctrl_o.alu_op = cpu_pkg::ALU_OR;
      cpu_pkg::OP_XOR: ctrl_o.alu_op = cpu_pkg::ALU_XOR;
      default:         ctrl_o.alu_op = cpu_pkg::ALU_ADD;
    endcase
    ctrl_o.alu2_sel = is_reg ? cpu_pkg::ALU2_B : cpu_pkg::ALU2_SVAL;

    case (state)
      cpu_pkg::S_FETCH: begin
        ctrl_o.ir_write = 1'b1;
        ctrl_o.pc_sel   = done ? cpu_pkg::PC_NEXT : cpu_pkg::PC_HOLD;
      end
      cpu_pkg::S_DECODE: begin
        ctrl_o.a_write = 1'b1;
        ctrl_o.b_write = 1'b1;
      end
      cpu_pkg::S_EXEC: begin
        if (is_branch && taken) ctrl_o.pc_sel = cpu_pkg::PC_REL;
        if (is_load || is_store) ctrl_o.mar_sel = cpu_pkg::MAR_ALU;
        if (is_store) ctrl_o.mdr_sel = cpu_pkg::MDR_B;
        // flags only from real alu ops
        ctrl_o.ccr_write = is_reg || (opcode_i == cpu_pkg::OP_ADDI);
      end
      cpu_pkg::S_MEM: begin
        ctrl_o.addr_mar = 1'b1;
        ctrl_o.byte_op  = is_byte;
        if (is_load) ctrl_o.mdr_sel = cpu_pkg::MDR_BUS;
      end
      cpu_pkg::S_WB: begin
        ctrl_o.reg_write = 1'b1;
        if (is_load) begin
          ctrl_o.reg_sel = cpu_pkg::REG_MDR;
        end else if (opcode_i == cpu_pkg::OP_LDI) begin
          ctrl_o.reg_sel = cpu_pkg::REG_UVAL;
        end else begin
          ctrl_o.reg_sel = cpu_pkg::REG_ALU;
        end
      end
      default: ; // halt, nothing moves
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_regfile (
  input  wire                 clk_i,
  input  wire                 rst_i,
  input  wire [3:0]           raddr1_i,
  input  wire [3:0]           raddr2_i,
  input  wire [3:0]           waddr_i,
  input  wire [`CPU_XLEN-1:0] wdata_i,
  input  wire                 we_i,
  output logic [`CPU_XLEN-1:0] rdata1_o,
  output logic [`CPU_XLEN-1:0] rdata2_o
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 4'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // r0 hardwired
  assign rdata1_o = (raddr1_i == 4'd0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 4'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_alu (
  input  wire [`CPU_XLEN-1:0] in1_i,
  input  wire [`CPU_XLEN-1:0] in2_i,
  input  wire cpu_pkg::alu_op_e op_i,
  output logic [`CPU_XLEN-1:0] out_o,
  output cpu_pkg::alu_flags_t flags_o
);

  localparam int MSB = `CPU_XLEN - 1;

  logic [`CPU_XLEN:0] res; // extra bit is carry out / borrow
  logic               ovf;

  always_comb begin
    ovf = 1'b0;
    case (op_i)
      cpu_pkg::ALU_ADD: begin
        res = {1'b0, in1_i} + {1'b0, in2_i};
        ovf = (in1_i[MSB] == in2_i[MSB]) && (res[MSB] != in1_i[MSB]);
      end
      cpu_pkg::ALU_SUB: begin
        res = {1'b0, in1_i} - {1'b0, in2_i};
        ovf = (in1_i[MSB] != in2_i[MSB]) && (res[MSB] != in1_i[MSB]);
      end
      cpu_pkg::ALU_AND: res = {1'b0, in1_i & in2_i};
      cpu_pkg::ALU_OR:  res = {1'b0, in1_i | in2_i};
      cpu_pkg::ALU_XOR: res = {1'b0, in1_i ^ in2_i};
      default:          res = {1'b0, in1_i};
    endcase
  end

  assign out_o = res[MSB:0];

  always_comb begin
    flags_o.carry    = res[`CPU_XLEN];
    flags_o.negative = res[MSB];
    flags_o.overflow = ovf;
    flags_o.zero     = (res[MSB:0] == '0);
  end

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  // instruction bits 31:28
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LDI  = 4'h6,
    OP_LD   = 4'h7,
    OP_ST   = 4'h8,
    OP_LDB  = 4'h9,
    OP_STB  = 4'ha,
    OP_BEQ  = 4'hb,
    OP_BNE  = 4'hc,
    OP_HALT = 4'hd
  } opcode_e;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

  typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_HALT} state_e;

  typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL} pc_sel_e;
  typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_e;
  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_B} mdr_sel_e;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} reg_sel_e;
  typedef enum logic {ALU2_B, ALU2_SVAL} alu2_sel_e;

  typedef struct packed {
    pc_sel_e   pc_sel;
    mar_sel_e  mar_sel;
    mdr_sel_e  mdr_sel;
    reg_sel_e  reg_sel;
    alu2_sel_e alu2_sel;
    alu_op_e   alu_op;
    logic      ir_write;
    logic      a_write;
    logic      b_write;
    logic      ccr_write;
    logic      reg_write;
    logic      addr_mar; // address from MAR, else PC
    logic      byte_op;  // single lane access
  } ctrl_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } alu_flags_t;

  typedef struct packed {
    logic [`CPU_XLEN-1:0] adr;
    logic [`CPU_XLEN-1:0] dat;
    logic [3:0]           sel;
    logic                 we;
  } bus_req_t;

endpackage

`default_nettype wire

// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width
`define CPU_XLEN 32

// general registers, r0 reads as zero
`define CPU_NREGS 16

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`endif
